/* verilog/fetch_macros.svh */
// Fetch front end configuration
// Widths, queue depth and reset PC shared by the front end and testbench
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Address and instruction widths
`define FETCH_AW              32
`define FETCH_INSN_W          32
`define FETCH_P_INSN_BYTES    2

// Fetch line geometry
`define FETCH_P_WIDTH         1
`define FETCH_SLOTS           2
`define FETCH_LINE_W          64

// Instruction queue holds 1 << IQ_P_DEPTH entries
`define IQ_P_DEPTH            3

`define FETCH_PC_RST          32'h0000_1000

`endif

/* verilog/fetch_pkg.sv */
// Fetch front end types
// PC, instruction and queue entry types, plus the fetch FSM states
`include "fetch_macros.svh"

package fetch_pkg;

   // Word PC, byte offset bits dropped
   typedef logic [`FETCH_AW-`FETCH_P_INSN_BYTES-1:0] pc_t;

   typedef logic [`FETCH_INSN_W-1:0] insn_t;

   // Line address above slot and byte bits
   typedef logic [`FETCH_AW-`FETCH_P_INSN_BYTES-`FETCH_P_WIDTH-1:0] line_pc_t;

   // One queue slot, instruction with its own PC
   typedef struct packed {
      insn_t insn;
      pc_t   pc;
   } iq_entry_t;

   typedef enum logic [1:0] {
      IDLE = 2'd0,
      WAIT = 2'd1,
      DROP = 2'd2
   } fetch_state_e;

endpackage

/* verilog/iq_push_if.sv */
// Instruction queue push bus
// Carries the slots of one fetched line from the aligner into the queue.
// Every slot with its valid bit set is written, in slot order.
`timescale 1ns/1ps
`include "fetch_macros.svh"

interface iq_push_if;

   logic                    push;
   logic [`FETCH_SLOTS-1:0] slot_valid;
   fetch_pkg::iq_entry_t    slot [`FETCH_SLOTS];

   modport src
   (
      output push,
      output slot_valid,
      output slot
   );

   modport dst
   (
      input  push,
      input  slot_valid,
      input  slot
   );

endinterface

/* verilog/pc_gen.sv */
// Fetch PC generator
// Holds the word PC of the next fetch. A flush loads the redirect
// target, an issued request steps to the base of the following line.
`timescale 1ns/1ps
`include "fetch_macros.svh"

module pc_gen
(
   input  logic             clk,
   input  logic             reset,
   input  logic             flush,
   input  fetch_pkg::pc_t   flush_tgt,
   input  logic             req_fire,
   output fetch_pkg::pc_t   fetch_pc
);
   localparam int PCW = `FETCH_AW - `FETCH_P_INSN_BYTES;
   localparam logic [`FETCH_AW-1:0] PC_RST_BYTE = `FETCH_PC_RST;

   fetch_pkg::line_pc_t next_line;

   // Next line base, slot bits cleared below
   assign next_line = fetch_pc[PCW-1:`FETCH_P_WIDTH] + fetch_pkg::line_pc_t'(1);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         fetch_pc <= PC_RST_BYTE[`FETCH_AW-1:`FETCH_P_INSN_BYTES];
      end
      else if (flush)
      begin
         fetch_pc <= flush_tgt;
      end
      else if (req_fire)
      begin
         fetch_pc <= {next_line, {`FETCH_P_WIDTH{1'b0}}};
      end
   end

   // Redirect target must be known whenever it is loaded
   a_flush_tgt_known: assert property (
      @(posedge clk) disable iff (reset)
      flush |-> !$isunknown(flush_tgt)
   )
   else $error("flush_tgt is unknown during flush");

endmodule

/* verilog/fetch_fsm.sv */
// Fetch request FSM
// Issues one memory read per line when the queue has room for a full
// line, waits for the response and hands it to the aligner. A flush
// while a read is in flight sends it to DROP, which swallows the stale
// response.
`timescale 1ns/1ps

module fetch_fsm
(
   input  logic clk,
   input  logic reset,
   input  logic flush,
   input  logic room,
   input  logic imem_rvalid,
   output logic req_fire,
   output logic resp_take
);

   fetch_pkg::fetch_state_e state;
   fetch_pkg::fetch_state_e state_nxt;

   assign req_fire  = (state == fetch_pkg::IDLE) && room && !flush;
   assign resp_take = (state == fetch_pkg::WAIT) && imem_rvalid && !flush;

   always_comb
   begin
      state_nxt = state;
      case (state)
         fetch_pkg::IDLE:
         begin
            if (req_fire)
               state_nxt = fetch_pkg::WAIT;
         end
         fetch_pkg::WAIT:
         begin
            // Response with flush is dropped right here
            if (imem_rvalid)
               state_nxt = fetch_pkg::IDLE;
            else if (flush)
               state_nxt = fetch_pkg::DROP;
         end
         fetch_pkg::DROP:
         begin
            if (imem_rvalid)
               state_nxt = fetch_pkg::IDLE;
         end
         default:
         begin
            state_nxt = fetch_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= fetch_pkg::IDLE;
      else
         state <= state_nxt;
   end

   // Memory answers only requests we made
   a_no_rvalid_idle: assert property (
      @(posedge clk) disable iff (reset)
      (state == fetch_pkg::IDLE) |-> !imem_rvalid
   )
   else $error("imem_rvalid arrived with no request outstanding");

endmodule

/* verilog/fetch_align.sv */
// Fetch line aligner
// Drives the line address to instruction memory, remembers which line
// and start slot each request was for, and splits the returned line into
// per-slot instructions. Slots ahead of an unaligned start are masked.
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_align
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req_fire,
   input  logic                      resp_take,
   input  fetch_pkg::pc_t            fetch_pc,
   output logic [`FETCH_AW-1:0]      imem_addr,
   input  logic [`FETCH_LINE_W-1:0]  imem_rdata,
   iq_push_if.src                    push
);
   localparam int PCW = `FETCH_AW - `FETCH_P_INSN_BYTES;
   localparam int LOW_BITS = `FETCH_P_WIDTH + `FETCH_P_INSN_BYTES;

   fetch_pkg::line_pc_t       req_line;
   logic [`FETCH_P_WIDTH-1:0] req_slot;
   logic [`FETCH_SLOTS-1:0]   valid_d;
   fetch_pkg::iq_entry_t      slot_d [`FETCH_SLOTS];

   // Byte address of the line holding fetch_pc
   assign imem_addr = {fetch_pc[PCW-1:`FETCH_P_WIDTH], {LOW_BITS{1'b0}}};

   always_ff @(posedge clk)
   begin
      if (req_fire)
         req_line <= fetch_pc[PCW-1:`FETCH_P_WIDTH];
   end

   // Start slot of the read in flight
   always_ff @(posedge clk)
   begin
      if (reset)
         req_slot <= '0;
      else if (req_fire)
         req_slot <= fetch_pc[`FETCH_P_WIDTH-1:0];
   end

   for (genvar i = 0; i < `FETCH_SLOTS; i++)
   begin : g_slot
      // Drop slots before the start of an unaligned fetch
      assign valid_d[i] = (`FETCH_P_WIDTH'(i) >= req_slot);

      assign slot_d[i] = '{
         insn: imem_rdata[i*`FETCH_INSN_W +: `FETCH_INSN_W],
         pc:   {req_line, `FETCH_P_WIDTH'(i)}
      };
   end

   assign push.push       = resp_take;
   assign push.slot_valid = valid_d;
   assign push.slot       = slot_d;

endmodule

/* verilog/inst_queue.sv */
// Instruction queue
// Circular buffer between fetch and decode. Takes up to one line of
// slots per push, packed in slot order, and hands one instruction per
// cycle to decode. Flush empties it, losing any push in that cycle.
// room tells the fetch FSM a whole line still fits.
`timescale 1ns/1ps
`include "fetch_macros.svh"

module inst_queue
(
   input  logic                clk,
   input  logic                reset,
   input  logic                flush,
   input  logic                id_pop,
   iq_push_if.dst              push,
   output logic                room,
   output logic                id_valid,
   output fetch_pkg::insn_t    id_ins,
   output fetch_pkg::pc_t      id_pc
);
   localparam int DEPTH = 1 << `IQ_P_DEPTH;
   localparam int CW = `IQ_P_DEPTH + 1;

   fetch_pkg::iq_entry_t   mem [DEPTH];
   logic [`IQ_P_DEPTH-1:0] rd_ptr;
   logic [`IQ_P_DEPTH-1:0] wr_ptr;
   logic [CW-1:0]          count;
   logic [CW-1:0]          free_cnt;
   logic [CW-1:0]          push_cnt;
   logic [`IQ_P_DEPTH-1:0] slot_ofs [`FETCH_SLOTS];
   logic                   pop_fire;

   // Each valid slot lands after the valid slots before it
   always_comb
   begin
      push_cnt = '0;
      for (int k = 0; k < `FETCH_SLOTS; k++)
      begin
         slot_ofs[k] = push_cnt[`IQ_P_DEPTH-1:0];
         if (push.push && push.slot_valid[k])
            push_cnt = push_cnt + 1'b1;
      end
   end

   assign free_cnt = CW'(DEPTH) - count;
   assign room     = (free_cnt >= CW'(`FETCH_SLOTS));
   assign id_valid = (count != '0);
   assign pop_fire = id_pop && id_valid;

   assign id_ins = mem[rd_ptr].insn;
   assign id_pc  = mem[rd_ptr].pc;

   always_ff @(posedge clk)
   begin
      for (int k = 0; k < `FETCH_SLOTS; k++)
      begin
         if (push.push && push.slot_valid[k])
            mem[wr_ptr + slot_ofs[k]] <= push.slot[k];
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset || flush)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         wr_ptr <= wr_ptr + push_cnt[`IQ_P_DEPTH-1:0];
         rd_ptr <= rd_ptr + `IQ_P_DEPTH'(pop_fire);
         count  <= count + push_cnt - CW'(pop_fire);
      end
   end

   // Fetch only issues a read when a whole line fits
   a_push_fits: assert property (
      @(posedge clk) disable iff (reset)
      push.push |-> (push_cnt <= free_cnt)
   )
   else $error("push of %0d slots with %0d free", push_cnt, free_cnt);

endmodule

/* verilog/fetch_top.sv */
// Instruction fetch front end
// PC generator, request FSM, line aligner and instruction queue.
// Reads one two-instruction line at a time from a simple memory port
// and feeds decode one instruction per cycle.
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_top
(
   input  logic                                        clk,
   input  logic                                        reset,
   input  logic                                        flush,
   input  logic [`FETCH_AW-`FETCH_P_INSN_BYTES-1:0]    flush_tgt,
   // Instruction memory
   output logic                                        imem_req,
   output logic [`FETCH_AW-1:0]                        imem_addr,
   input  logic                                        imem_rvalid,
   input  logic [`FETCH_LINE_W-1:0]                    imem_rdata,
   // To decode
   output logic                                        id_valid,
   output logic [`FETCH_INSN_W-1:0]                    id_ins,
   output logic [`FETCH_AW-`FETCH_P_INSN_BYTES-1:0]    id_pc,
   input  logic                                        id_pop
);

   fetch_pkg::pc_t fetch_pc;
   logic           req_fire;
   logic           resp_take;
   logic           room;

   iq_push_if u_push ();

   pc_gen u_pc_gen
   (
      .clk       (clk),
      .reset     (reset),
      .flush     (flush),
      .flush_tgt (flush_tgt),
      .req_fire  (req_fire),
      .fetch_pc  (fetch_pc)
   );

   fetch_fsm u_fetch_fsm
   (
      .clk         (clk),
      .reset       (reset),
      .flush       (flush),
      .room        (room),
      .imem_rvalid (imem_rvalid),
      .req_fire    (req_fire),
      .resp_take   (resp_take)
   );

   fetch_align u_fetch_align
   (
      .clk        (clk),
      .reset      (reset),
      .req_fire   (req_fire),
      .resp_take  (resp_take),
      .fetch_pc   (fetch_pc),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .push       (u_push.src)
   );

   inst_queue u_inst_queue
   (
      .clk      (clk),
      .reset    (reset),
      .flush    (flush),
      .id_pop   (id_pop),
      .push     (u_push.dst),
      .room     (room),
      .id_valid (id_valid),
      .id_ins   (id_ins),
      .id_pc    (id_pc)
   );

   // Request strobe goes straight to memory
   assign imem_req = req_fire;

endmodule

/* bench/fetch_tb.sv */
// Fetch front end testbench
// Runs test steps from a data file against fetch_top. A memory model answers
// each line read after a random delay, and every popped instruction is
// checked against the expected PC sequence and the instruction fill rule.
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_tb;

   localparam int          TIMEOUT     = 200;
   localparam logic [31:0] INSN_KEY    = 32'h5a5a_5a5a;
   localparam logic [31:0] PC_RST_BYTE = `FETCH_PC_RST;

   logic                      clk;
   logic                      reset;
   logic                      flush;
   logic [29:0]               flush_tgt;
   logic                      imem_req;
   logic [`FETCH_AW-1:0]      imem_addr;
   logic                      imem_rvalid;
   logic [`FETCH_LINE_W-1:0]  imem_rdata;
   logic                      id_valid;
   logic [`FETCH_INSN_W-1:0]  id_ins;
   logic [29:0]               id_pc;
   logic                      id_pop;

   logic [31:0]    lfsr;
   fetch_pkg::pc_t exp_pc;
   int             errors;
   int             checks;
   int             tests_run;
   bit             aborted;

   fetch_top dut0
   (
      .clk         (clk),
      .reset       (reset),
      .flush       (flush),
      .flush_tgt   (flush_tgt),
      .imem_req    (imem_req),
      .imem_addr   (imem_addr),
      .imem_rvalid (imem_rvalid),
      .imem_rdata  (imem_rdata),
      .id_valid    (id_valid),
      .id_ins      (id_ins),
      .id_pc       (id_pc),
      .id_pop      (id_pop)
   );

   always #10 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'hA300_0000;
      else
         return s >> 1;
   endfunction

   // One LFSR step per bit taken
   task automatic random_bits(input int n, output int val);
      val = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         val  = (val << 1) | int'(lfsr[0]);
      end
   endtask

   // Instruction word derived from its word PC
   function automatic logic [31:0] insn_for(input fetch_pkg::pc_t pc);
      return {2'b00, pc} ^ INSN_KEY;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   // Instruction memory model with one read in flight and 1 to 4 cycles of latency
   always
   begin : memory_model
      logic [31:0]    addr;
      fetch_pkg::pc_t base;
      int             lat;
      @(negedge clk);
      if (!reset && imem_req === 1'b1)
      begin
         addr = imem_addr;
         // Reads always start on a line boundary
         check_value("imem_addr[2:0]", 32'(addr[2:0]), 32'd0);
         random_bits(2, lat);
         lat = lat + 1;
         @(posedge clk);
         repeat (lat - 1) @(posedge clk);
         #1;
         base        = addr[31:2];
         imem_rdata  = {insn_for(base + fetch_pkg::pc_t'(1)), insn_for(base)};
         imem_rvalid = 1'b1;
         @(posedge clk);
         #1;
         imem_rvalid = 1'b0;
      end
   end

   task automatic flush_to(input logic [31:0] tgt);
      id_pop    = 1'b0;
      flush     = 1'b1;
      flush_tgt = tgt[29:0];
      @(posedge clk);
      #1;
      flush  = 1'b0;
      exp_pc = tgt[29:0];
   endtask

   // Returns one cycle after a request edge
   task automatic wait_request(output bit ok);
      int waited;
      ok     = 1'b0;
      waited = 0;
      while (!ok && waited < TIMEOUT)
      begin
         @(negedge clk);
         if (imem_req === 1'b1)
            ok = 1'b1;
         @(posedge clk);
         #1;
         waited++;
      end
      if (!ok)
      begin
         $display("Timeout: no memory request within %0d cycles after a flush", TIMEOUT);
         errors++;
      end
   endtask

   // Hold id_pop high until the head is taken and check it first
   task automatic pop_one(input int gap, output bit ok);
      int waited;
      ok     = 1'b0;
      waited = 0;
      if (gap > 0)
      begin
         id_pop = 1'b0;
         repeat (gap)
         begin
            @(posedge clk);
            #1;
         end
      end
      id_pop = 1'b1;
      while (!ok && waited < TIMEOUT)
      begin
         @(negedge clk);
         if (id_valid === 1'b1)
         begin
            check_value("id_pc", 32'(id_pc), 32'(exp_pc));
            check_value("id_ins", id_ins, insn_for(exp_pc));
            ok = 1'b1;
         end
         @(posedge clk);
         #1;
         waited++;
      end
      if (ok)
         exp_pc = exp_pc + fetch_pkg::pc_t'(1);
      else
      begin
         $display("Timeout: id_valid stayed low for %0d cycles, no instruction to pop",
                  TIMEOUT);
         errors++;
      end
   endtask

   task automatic run_test(input int mode, input logic [31:0] tgt, input int count,
                           input int max_gap);
      int errs_before;
      int gap;
      bit ok;
      errs_before = errors;
      tests_run++;
      ok = 1'b1;
      if (mode == 1)
         flush_to(tgt);
      else if (mode == 2)
      begin
         // Fetch a decoy line and redirect while its read is in flight
         flush_to(tgt + 32'd64);
         wait_request(ok);
         if (ok)
            flush_to(tgt);
      end
      for (int i = 0; i < count && ok; i++)
      begin
         gap = 0;
         if (max_gap > 0)
         begin
            random_bits(4, gap);
            gap = gap % (max_gap + 1);
         end
         pop_one(gap, ok);
      end
      id_pop = 1'b0;
      if (!ok)
         aborted = 1'b1;
      $display("test %0d done: mode %0d, %0d pops, %0d errors", tests_run, mode, count,
               errors - errs_before);
   endtask

   initial
   begin : main
      int                fd;
      int                n;
      int                mode;
      logic [31:0]       tgt;
      int                count;
      int                max_gap;
      bit                done;
      logic [8*256-1:0]  skip;
      clk         = 1'b0;
      reset       = 1'b1;
      flush       = 1'b0;
      flush_tgt   = '0;
      imem_rvalid = 1'b0;
      imem_rdata  = '0;
      id_pop      = 1'b0;
      lfsr        = 32'hab90;
      errors      = 0;
      checks      = 0;
      tests_run   = 0;
      aborted     = 1'b0;
      done        = 1'b0;
      exp_pc      = PC_RST_BYTE[31:2];
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;

      fd = $fopen("bench/fetch_tests.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the test data file bench/fetch_tests.txt");
         errors++;
      end
      else
      begin
         while (!done && !aborted)
         begin
            n = $fscanf(fd, "%d %h %d %d", mode, tgt, count, max_gap);
            if (n == 4)
               run_test(mode, tgt, count, max_gap);
            else if (n == 0)
            begin
               // Skip the rest of a comment line
               if ($fgets(skip, fd) == 0)
                  done = 1'b1;
            end
            else if (n < 0)
               done = 1'b1;
            else
            begin
               $display("Malformed line in the test data file after test %0d", tests_run);
               errors++;
               aborted = 1'b1;
            end
         end
         $fclose(fd);
      end
      if (tests_run == 0)
      begin
         $display("No test steps were read from the test data file");
         errors++;
      end

      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* bench/fetch_tests.txt */
# Fetch front end test steps, one test per line
# flush mode (0 none, 1 flush, 2 flush with a read in flight), target word PC hex, pops, max gap
0 00000000 12 0
0 00000000 10 2
1 00000800 9 0
1 00000c01 7 1
0 00000000 6 0
1 00002003 6 0
0 00000000 20 12
1 0000a001 14 15
0 00000000 16 9
2 00003000 8 0
2 00003405 8 3
0 00000000 10 15
1 00000101 5 0
2 00000777 9 6
1 00004000 24 4
0 00000000 18 14
2 00005002 6 0
1 00006ffd 12 2
0 00000000 30 5
1 00007ff1 10 11
2 00008001 16 1

/* compile.f */
+incdir+verilog
verilog/fetch_pkg.sv
verilog/iq_push_if.sv
verilog/pc_gen.sv
verilog/fetch_fsm.sv
verilog/fetch_align.sv
verilog/inst_queue.sv
verilog/fetch_top.sv
bench/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the fetch front end testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module fetch_tb -o fetch_sim

status=0
./obj_dir/fetch_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
if grep -q "Test failures found" sim.log; then
   exit 1
fi
exit 0
